// File: common/req_dist_defs.svh
`ifndef REQ_DIST_DEFS_SVH
`define REQ_DIST_DEFS_SVH

// Fan-out of the distributor
`define REQ_NUM_REQUESTORS 4

// Payload field widths
`define REQ_ADDR_W 32
`define REQ_DATA_W 32
`define REQ_TAG_W  8

// Request FIFO sizing
`define REQ_FIFO_DEPTH  16
`define REQ_PROG_THRESH 12

// Cycles of reset-busy after reset is released
`define REQ_RST_BUSY_CYCLES 4

`endif

// File: common/req_dist_pkg.sv
`default_nettype none

`include "req_dist_defs.svh"

package req_dist_pkg;

  // One bit per output requestor
  typedef logic [`REQ_NUM_REQUESTORS-1:0] requestor_mask_t;

  // ----------------------------------------------------------
  // Memory request packet
  // ----------------------------------------------------------
  // dest sits in the top bits, 76 bits total
  typedef struct packed {
    requestor_mask_t        dest;
    logic [`REQ_TAG_W-1:0]  tag;
    logic [`REQ_ADDR_W-1:0] addr;
    logic [`REQ_DATA_W-1:0] data;
  } request_payload_t;

endpackage : req_dist_pkg

`default_nettype wire

// File: dv/req_dist_props.sv
`timescale 1ns/1ps
`default_nettype none

module req_dist_props (
  input logic                           ap_clk,
  input logic                           areset_control,
  input req_dist_pkg::requestor_mask_t  out_valid,
  input logic                           fifo_rd_en,
  input req_dist_pkg::request_payload_t fifo_dout,
  input logic                           fifo_wr_en,
  input logic                           fifo_rst_busy,
  input logic                           fifo_full,
  input logic                           fifo_empty
);

  req_dist_pkg::requestor_mask_t pop_dest;

  assign pop_dest = fifo_dout.dest;

  // Output pulses trace back to a FIFO pop two cycles earlier, only on its targets
  valid_within_dest : assert property (@(posedge ap_clk) disable iff (areset_control)
    (out_valid != '0) |->
      ($past(fifo_rd_en, 2) && ((out_valid & ~$past(pop_dest, 2)) == '0)))
    else $error("out_valid set outside the popped packet's dest");

  // FIFO still coming out of reset
  no_push_while_busy : assert property (@(posedge ap_clk) disable iff (areset_control)
    fifo_wr_en |-> !fifo_rst_busy)
    else $error("push requested while the FIFO reports reset-busy");

  full_empty_exclusive : assert property (@(posedge ap_clk) disable iff (areset_control)
    !(fifo_full && fifo_empty))
    else $error("FIFO full and empty at the same time");

endmodule : req_dist_props

bind request_demux req_dist_props props_i (
  .ap_clk         (ap_clk),
  .areset_control (areset_control),
  .out_valid      (out_valid),
  .fifo_rd_en     (fifo_rd_en),
  .fifo_dout      (fifo_dout),
  .fifo_wr_en     (fifo_wr_en),
  .fifo_rst_busy  (fifo_rst_busy),
  .fifo_full      (fifo_full),
  .fifo_empty     (fifo_empty)
);

`default_nettype wire

// File: dv/req_dist_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "req_dist_defs.svh"

module req_dist_tb;

  localparam int NUM_REQ        = `REQ_NUM_REQUESTORS;
  localparam int FILL_FIRST     = 11;
  localparam int NUM_ROWS       = FILL_FIRST + `REQ_PROG_THRESH;
  localparam int TIMEOUT_CYCLES = NUM_ROWS * 40 + 200;

  typedef struct {
    req_dist_pkg::requestor_mask_t dest;
    logic [`REQ_DATA_W-1:0]        data;
    req_dist_pkg::requestor_mask_t ready_pat;
    int                            hold;
  } stim_row_t;

  logic                           ap_clk;
  logic                           areset_control;
  logic                           in_valid;
  req_dist_pkg::request_payload_t in_payload;
  req_dist_pkg::requestor_mask_t  ready;
  req_dist_pkg::requestor_mask_t  out_valid;
  req_dist_pkg::request_payload_t out_payload;
  logic                           fifo_full;
  logic                           fifo_empty;
  logic                           fifo_prog_full;
  logic                           setup;

  stim_row_t                      rows [NUM_ROWS];
  req_dist_pkg::request_payload_t exp_q [NUM_REQ][$];
  req_dist_pkg::requestor_mask_t  rdy_hist [3];
  integer                         seed;
  int                             errors = 0;
  int                             tests = 0;
  int                             delivered = 0;
  int                             cycles = 0;
  int                             mark;

  req_dist_top dut_i (
    .ap_clk         (ap_clk),
    .areset_control (areset_control),
    .in_valid       (in_valid),
    .in_payload     (in_payload),
    .ready          (ready),
    .out_valid      (out_valid),
    .out_payload    (out_payload),
    .fifo_full      (fifo_full),
    .fifo_empty     (fifo_empty),
    .fifo_prog_full (fifo_prog_full),
    .setup          (setup)
  );

  initial ap_clk = 1'b0;
  always #2 ap_clk = ~ap_clk;

  // Run limit
  always @(posedge ap_clk) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles with %0d packets still expected", cycles,
               pending_count());
      $display("TB FAILED");
      $finish;
    end
  end

  // ----------------------------------------------------------
  // Compare tasks
  // ----------------------------------------------------------
  task automatic check_payload(string name, req_dist_pkg::request_payload_t got,
                               req_dist_pkg::request_payload_t exp);
    if (got !== exp) begin
      errors++;
      $display("ERROR %0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_mask(string name, req_dist_pkg::requestor_mask_t got,
                            req_dist_pkg::requestor_mask_t exp);
    if (got !== exp) begin
      errors++;
      $display("ERROR %0t %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  task automatic check_flag(string name, logic got, logic exp);
    if (got !== exp) begin
      errors++;
      $display("ERROR %0t %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  function automatic int pending_count();
    int total;
    total = 0;
    for (int i = 0; i < NUM_REQ; i++) begin
      total += exp_q[i].size();
    end
    return total;
  endfunction

  // ----------------------------------------------------------
  // Scoreboard
  // ----------------------------------------------------------
  // Ready as seen by the DUT at the last three rising edges
  always @(posedge ap_clk) begin
    rdy_hist[2] <= rdy_hist[1];
    rdy_hist[1] <= rdy_hist[0];
    rdy_hist[0] <= ready;
  end

  always @(negedge ap_clk) begin : monitor
    req_dist_pkg::request_payload_t exp_pkt;
    logic                           first;
    if (!areset_control && out_valid != '0) begin
      first = 1'b1;
      for (int i = 0; i < NUM_REQ; i++) begin
        if (out_valid[i]) begin
          if (!rdy_hist[2][i]) begin
            errors++;
            $display("Requestor %0d got a packet at %0t while its ready was low", i, $time);
          end
          if (exp_q[i].size() == 0) begin
            errors++;
            $display("Requestor %0d got a packet at %0t that nobody sent to it", i, $time);
          end else begin
            exp_pkt = exp_q[i].pop_front();
            // Every target of a multicast pulses in this one cycle
            if (first) begin
              check_mask("out_valid", out_valid, exp_pkt.dest);
            end
            first = 1'b0;
            check_payload($sformatf("out_payload[%0d]", i), out_payload, exp_pkt);
          end
        end
      end
      delivered++;
    end
  end

  // ----------------------------------------------------------
  // Stimulus
  // ----------------------------------------------------------
  task automatic set_row(int idx, req_dist_pkg::requestor_mask_t dest,
                         logic [`REQ_DATA_W-1:0] data,
                         req_dist_pkg::requestor_mask_t rdy, int hold);
    rows[idx].dest      = dest;
    rows[idx].data      = data;
    rows[idx].ready_pat = rdy;
    rows[idx].hold      = hold;
  endtask

  task automatic build_table();
    set_row(0, 4'b0001, 32'h1000_0001, 4'b1111, 1);
    set_row(1, 4'b0010, 32'h1000_0002, 4'b1111, 0);
    set_row(2, 4'b0100, 32'h1000_0003, 4'b1111, 2);
    set_row(3, 4'b1000, 32'h1000_0004, 4'b1111, 0);
    set_row(4, 4'b1011, 32'h2000_0001, 4'b1111, 1);
    set_row(5, 4'b1111, 32'h2000_0002, 4'b1111, 0);
    set_row(6, 4'b0000, 32'h3000_0001, 4'b1111, 1);
    set_row(7, 4'b0100, 32'h3000_0002, 4'b1111, 0);
    // Requestor 0 held off
    set_row(8, 4'b0001, 32'h4000_0001, 4'b1110, 2);
    set_row(9, 4'b0010, 32'h4000_0002, 4'b1110, 2);
    set_row(10, 4'b0011, 32'h4000_0003, 4'b1110, 4);
    for (int i = 0; i < `REQ_PROG_THRESH; i++) begin
      set_row(FILL_FIRST + i, NUM_REQ'(1 << (i % NUM_REQ)), 32'h5000_0000 + i, 4'b0000, 1);
    end
  endtask

  task automatic send_row(int idx);
    req_dist_pkg::request_payload_t pkt;
    ready = rows[idx].ready_pat;
    repeat (rows[idx].hold) @(negedge ap_clk);
    while (fifo_prog_full || setup) @(negedge ap_clk);
    pkt.dest   = rows[idx].dest;
    pkt.tag    = `REQ_TAG_W'(idx);
    pkt.addr   = $random(seed);
    pkt.data   = rows[idx].data;
    in_payload = pkt;
    in_valid   = 1'b1;
    for (int i = 0; i < NUM_REQ; i++) begin
      if (pkt.dest[i]) begin
        exp_q[i].push_back(pkt);
      end
    end
    @(negedge ap_clk);
    in_valid = 1'b0;
  endtask

  task automatic run_rows(int first, int last);
    for (int r = first; r <= last; r++) begin
      send_row(r);
    end
  endtask

  task automatic drain_all();
    ready = '1;
    while (pending_count() != 0) @(negedge ap_clk);
    repeat (2) @(negedge ap_clk);
    check_flag("fifo_empty", fifo_empty, 1'b1);
    check_mask("out_valid", out_valid, '0);
  endtask

  // A filtered packet must never reach the FIFO
  task automatic expect_empty_for(int n);
    repeat (n) begin
      @(negedge ap_clk);
      check_flag("fifo_empty", fifo_empty, 1'b1);
    end
  endtask

  task automatic wait_setup_low();
    int n;
    n = 0;
    while (setup && n < `REQ_RST_BUSY_CYCLES + 2) begin
      @(negedge ap_clk);
      n++;
    end
    if (setup) begin
      errors++;
      $display("setup still high %0d cycles after reset was released", n);
    end
  endtask

  task automatic end_test(string name);
    tests++;
    $display("Test %s finished, %0d errors so far", name, errors);
  endtask

  // ----------------------------------------------------------
  // Test sequence
  // ----------------------------------------------------------
  initial begin
    seed           = 32'h09d0_cea9;
    areset_control = 1'b1;
    in_valid       = 1'b0;
    in_payload     = '0;
    ready          = '0;
    build_table();
    repeat (10) @(negedge ap_clk);
    areset_control = 1'b0;

    check_mask("out_valid", out_valid, '0);
    check_flag("fifo_empty", fifo_empty, 1'b1);
    check_flag("fifo_full", fifo_full, 1'b0);
    check_flag("fifo_prog_full", fifo_prog_full, 1'b0);
    check_flag("setup", setup, 1'b1);
    wait_setup_low();
    end_test("reset");

    run_rows(0, 3);
    drain_all();
    end_test("unicast");

    run_rows(4, 5);
    drain_all();
    end_test("multicast");

    run_rows(6, 6);
    expect_empty_for(4);
    run_rows(7, 7);
    drain_all();
    end_test("drop");

    mark = delivered;
    run_rows(8, 10);
    check_flag("fifo_empty", fifo_empty, 1'b0);
    if (delivered != mark) begin
      errors++;
      $display("Packets were delivered past a stalled head");
    end
    drain_all();
    end_test("stall");

    run_rows(FILL_FIRST, NUM_ROWS - 1);
    repeat (3) @(negedge ap_clk);
    check_flag("fifo_prog_full", fifo_prog_full, 1'b1);
    check_flag("fifo_empty", fifo_empty, 1'b0);
    drain_all();
    check_flag("fifo_prog_full", fifo_prog_full, 1'b0);
    end_test("fill");

    $display("Done: %0d tests, %0d packets delivered, %0d errors", tests, delivered, errors);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule : req_dist_tb

`default_nettype wire

// File: hw/req_dist_top.sv
`timescale 1ns/1ps
`default_nettype none

module req_dist_top (
  input  logic                           ap_clk,
  input  logic                           areset_control,
  input  logic                           in_valid,
  input  req_dist_pkg::request_payload_t in_payload,
  input  req_dist_pkg::requestor_mask_t  ready,
  output req_dist_pkg::requestor_mask_t  out_valid,
  output req_dist_pkg::request_payload_t out_payload,
  output logic                           fifo_full,
  output logic                           fifo_empty,
  output logic                           fifo_prog_full,
  output logic                           setup
);

  // ----------------------------------------------------------
  // Demux wiring
  // ----------------------------------------------------------
  req_dist_pkg::requestor_mask_t  demux_out_valid;
  req_dist_pkg::request_payload_t demux_out_payload;
  logic                           demux_fifo_full;
  logic                           demux_fifo_empty;
  logic                           demux_fifo_prog_full;
  logic                           demux_setup;

  // Reset goes straight through, no extra stage
  request_demux u_request_demux (
    .ap_clk         (ap_clk),
    .areset_control (areset_control),
    .in_valid       (in_valid),
    .in_payload     (in_payload),
    .ready          (ready),
    .out_valid      (demux_out_valid),
    .out_payload    (demux_out_payload),
    .fifo_full      (demux_fifo_full),
    .fifo_empty     (demux_fifo_empty),
    .fifo_prog_full (demux_fifo_prog_full),
    .setup          (demux_setup)
  );

  // Outputs
  assign out_valid      = demux_out_valid;
  assign out_payload    = demux_out_payload;
  assign fifo_full      = demux_fifo_full;
  assign fifo_empty     = demux_fifo_empty;
  assign fifo_prog_full = demux_fifo_prog_full;
  assign setup          = demux_setup;

endmodule : req_dist_top

`default_nettype wire

// File: hw/req_fifo_sync.sv
`timescale 1ns/1ps
`default_nettype none

`include "req_dist_defs.svh"

module req_fifo_sync #(
  parameter int DEPTH           = `REQ_FIFO_DEPTH,
  parameter int PROG_THRESH     = `REQ_PROG_THRESH,
  parameter int RST_BUSY_CYCLES = `REQ_RST_BUSY_CYCLES
) (
  input  logic                          ap_clk,
  input  logic                          areset_control,
  input  logic                          wr_en,
  input  req_dist_pkg::request_payload_t din,
  input  logic                          rd_en,
  output req_dist_pkg::request_payload_t dout,
  output logic                          full,
  output logic                          empty,
  output logic                          prog_full,
  output logic                          rst_busy
);

  localparam int PTR_W  = $clog2(DEPTH);
  localparam int CNT_W  = $clog2(DEPTH + 1);
  localparam int BUSY_W = $clog2(RST_BUSY_CYCLES + 1);

  req_dist_pkg::request_payload_t mem [DEPTH];

  logic [PTR_W-1:0]  wr_ptr;
  logic [PTR_W-1:0]  rd_ptr;
  logic [CNT_W-1:0]  count;
  logic [BUSY_W-1:0] busy_cnt;
  logic              do_wr;
  logic              do_rd;

  // ----------------------------------------------------------
  // Reset-busy window
  // ----------------------------------------------------------
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      busy_cnt <= BUSY_W'(RST_BUSY_CYCLES);
    end else if (busy_cnt != '0) begin
      busy_cnt <= busy_cnt - 1'b1;
    end
  end

  assign rst_busy = (busy_cnt != '0);

  // Accesses are dropped while busy or when they would overflow
  assign do_wr = wr_en & ~full & ~rst_busy;
  assign do_rd = rd_en & ~empty & ~rst_busy;

  // ----------------------------------------------------------
  // Pointers and occupancy
  // ----------------------------------------------------------
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_wr) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_rd) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({do_wr, do_rd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Storage array
  always_ff @(posedge ap_clk) begin
    if (do_wr) begin
      mem[wr_ptr] <= din;
    end
  end

  // ----------------------------------------------------------
  // Status and first-word-fall-through read port
  // ----------------------------------------------------------
  assign dout      = mem[rd_ptr];
  assign empty     = (count == '0);
  assign full      = (count == CNT_W'(DEPTH));
  assign prog_full = (count >= CNT_W'(PROG_THRESH));

endmodule : req_fifo_sync

`default_nettype wire

// File: req_dist_top.f
+incdir+common
common/req_dist_pkg.sv
hw/req_fifo_sync.sv
request_demux/request_demux.sv
hw/req_dist_top.sv
dv/req_dist_props.sv
dv/req_dist_tb.sv

// File: request_demux/request_demux.sv
`timescale 1ns/1ps
`default_nettype none

module request_demux (
  input  logic                           ap_clk,
  input  logic                           areset_control,
  input  logic                           in_valid,
  input  req_dist_pkg::request_payload_t in_payload,
  input  req_dist_pkg::requestor_mask_t  ready,
  output req_dist_pkg::requestor_mask_t  out_valid,
  output req_dist_pkg::request_payload_t out_payload,
  output logic                           fifo_full,
  output logic                           fifo_empty,
  output logic                           fifo_prog_full,
  output logic                           setup
);

  // ----------------------------------------------------------
  // Internal signals
  // ----------------------------------------------------------
  logic                           in_valid_q;
  req_dist_pkg::request_payload_t in_payload_q;
  req_dist_pkg::requestor_mask_t  ready_q;

  logic                           fifo_wr_en;
  logic                           fifo_rd_en;
  logic                           fifo_rst_busy;
  req_dist_pkg::request_payload_t fifo_dout;
  req_dist_pkg::requestor_mask_t  head_ready;

  // Packet popped last cycle, waiting for the output stage
  logic                           head_valid;
  req_dist_pkg::request_payload_t head_payload;

  // ----------------------------------------------------------
  // Input and ready registers
  // ----------------------------------------------------------
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      in_valid_q <= 1'b0;
      ready_q    <= '0;
    end else begin
      in_valid_q <= in_valid;
      ready_q    <= ready;
    end
  end

  always_ff @(posedge ap_clk) begin
    in_payload_q <= in_payload;
  end

  // Zero-destination packets never enter the FIFO
  assign fifo_wr_en = in_valid_q & (|in_payload_q.dest);

  // ----------------------------------------------------------
  // Multicast pop
  // ----------------------------------------------------------
  // Head leaves only when every named requestor was ready
  assign head_ready = ready_q & fifo_dout.dest;
  assign fifo_rd_en = ~fifo_empty & (head_ready == fifo_dout.dest);

  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      head_valid <= 1'b0;
    end else begin
      head_valid <= fifo_rd_en;
    end
  end

  always_ff @(posedge ap_clk) begin
    if (fifo_rd_en) begin
      head_payload <= fifo_dout;
    end
  end

  // ----------------------------------------------------------
  // Output stage
  // ----------------------------------------------------------
  // All targets of one packet pulse in the same cycle
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      out_valid <= '0;
    end else begin
      out_valid <= head_valid ? head_payload.dest : '0;
    end
  end

  // Shared payload bus
  always_ff @(posedge ap_clk) begin
    out_payload <= head_payload;
  end

  // Setup flag, held high through reset
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      setup <= 1'b1;
    end else begin
      setup <= fifo_rst_busy;
    end
  end

  // ----------------------------------------------------------
  // Request FIFO
  // ----------------------------------------------------------
  req_fifo_sync u_req_fifo (
    .ap_clk         (ap_clk),
    .areset_control (areset_control),
    .wr_en          (fifo_wr_en),
    .din            (in_payload_q),
    .rd_en          (fifo_rd_en),
    .dout           (fifo_dout),
    .full           (fifo_full),
    .empty          (fifo_empty),
    .prog_full      (fifo_prog_full),
    .rst_busy       (fifo_rst_busy)
  );

endmodule : request_demux

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# Build and run the request distributor testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  -f req_dist_top.f --top-module req_dist_tb -o Vreq_dist_tb > "$BUILD_LOG" 2>&1
status=$?
if [ $status -ne 0 ]; then
  cat "$BUILD_LOG"
  echo "Verilator build failed with status $status"
  exit 1
fi

./obj_dir/Vreq_dist_tb > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "TB FAILED" "$SIM_LOG"; then
  exit 1
fi
exit 0
